/* rtl/uop_pkg.sv */
package uop_pkg;

    // micro-op operation, 4-bit encoding
    typedef enum logic [3:0] {
        ALU_ADD,
        LD_B,
        LD_H,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL_W,
        SC_W
    } op_e;

    // one issued micro-op
    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        logic [4:0]  rd;
        logic [31:0] rj_data;
        // store data for ST_* and SC_W
        logic [31:0] rk_data;
        logic [31:0] imm;
    } issue_pkt_t;

    // anything that reaches the data cache
    function automatic logic is_mem_op(op_e op);
        return op != ALU_ADD;
    endfunction

    function automatic logic is_store_op(op_e op);
        return op inside {ST_B, ST_H, ST_W, SC_W};
    endfunction

    function automatic logic is_atomic_op(op_e op);
        return op inside {LL_W, SC_W};
    endfunction

    // access size in bytes
    function automatic logic [2:0] access_bytes(op_e op);
        logic [2:0] bytes;
        case (op)
            LD_B, ST_B: bytes = 3'd1;
            LD_H, ST_H: bytes = 3'd2;
            default:    bytes = 3'd4;
        endcase
        return bytes;
    endfunction

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

    // exception code carried with each packet
    typedef enum logic [1:0] {
        NONE,
        // misaligned address
        ALE,
        // no translation for the address
        TLBR
    } excp_e;

    // packet between addr_xlate, mem_buf and wb_tx
    typedef struct packed {
        logic [31:0]   pc;
        uop_pkg::op_e  op;
        logic [4:0]    rd;
        // physical address, add result, or the faulting address
        logic [31:0]   value;
        logic [31:0]   wdata;
        excp_e         excp;
    } mem_pkt_t;

    // packet handed to writeback
    typedef struct packed {
        logic [31:0]   pc;
        logic [4:0]    rd;
        uop_pkg::op_e  op;
        logic [31:0]   value;
        excp_e         excp;
    } wb_pkt_t;

    // data-cache request, one pulse per access
    typedef struct packed {
        logic        is_store;
        logic        is_atomic;
        // byte lanes within the word
        logic [3:0]  strb;
        logic [31:0] pa;
        // store data already moved onto its lanes
        logic [31:0] wdata;
    } dc_req_t;

endpackage

/* rtl/issue_rx.sv */
`timescale 1ns/100ps

module issue_rx #(
    parameter int RX_DEPTH = 4
) (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic                in_valid,
    input  uop_pkg::issue_pkt_t in_pkt,
    input  logic                next_allowin,
    output logic                in_credit,
    output logic                rx_valid,
    output uop_pkg::issue_pkt_t rx_pkt
);
    import uop_pkg::*;

    localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CNT_W = $clog2(RX_DEPTH + 1);

    typedef enum logic {
        RUN,
        DRAIN
    } rx_state_e;

    rx_state_e        state;
    issue_pkt_t       mem [RX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(RX_DEPTH));
    // new entries only while running, the sender's credits keep it from overflowing
    assign push = in_valid && (state == RUN) && !full;
    // head leaves either toward addr_xlate or, while draining, to nowhere
    assign pop = (count != '0) && ((state == RUN) ? next_allowin : 1'b1);

    assign rx_valid = (state == RUN) && (count != '0);
    assign rx_pkt   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state     <= RUN;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(push) - CNT_W'(pop);
            // one credit back per freed entry
            in_credit <= pop;
            if (flush) begin
                state <= DRAIN;
            end else if (state == DRAIN && count == '0) begin
                state <= RUN;
            end
        end
    end

endmodule

/* rtl/addr_xlate.sv */
`timescale 1ns/100ps

module addr_xlate #(
    parameter logic [2:0] DMW_VSEG = 3'b101,
    parameter logic [2:0] DMW_PSEG = 3'b000
) (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic                prev_valid,
    input  uop_pkg::issue_pkt_t prev_pkt,
    input  logic                next_allowin,
    output logic                allowin,
    output logic                xl_valid,
    output mem_pkg::mem_pkt_t   xl_pkt
);
    import uop_pkg::*;
    import mem_pkg::*;

    logic [31:0] va;
    logic [2:0]  bytes;
    logic        misaligned;
    logic        in_window;
    mem_pkt_t    nxt_pkt;
    logic        load;

    // effective address, also the ALU_ADD result
    assign va    = prev_pkt.rj_data + prev_pkt.imm;
    assign bytes = access_bytes(prev_pkt.op);

    always_comb begin
        case (bytes)
            3'd2:    misaligned = va[0];
            3'd4:    misaligned = |va[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // single direct-mapped window on the top three bits
    assign in_window = (va[31:29] == DMW_VSEG);

    always_comb begin
        nxt_pkt.pc    = prev_pkt.pc;
        nxt_pkt.op    = prev_pkt.op;
        nxt_pkt.rd    = prev_pkt.rd;
        nxt_pkt.wdata = prev_pkt.rk_data;
        nxt_pkt.value = va;
        nxt_pkt.excp  = NONE;
        if (is_mem_op(prev_pkt.op)) begin
            // ALE wins over TLBR, a faulting packet keeps the virtual address
            if (misaligned) begin
                nxt_pkt.excp = ALE;
            end else if (!in_window) begin
                nxt_pkt.excp = TLBR;
            end else begin
                nxt_pkt.value = {DMW_PSEG, va[28:0]};
            end
        end
    end

    assign allowin = !xl_valid || next_allowin;
    assign load    = prev_valid && allowin;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            xl_valid <= 1'b0;
        end else if (flush) begin
            xl_valid <= 1'b0;
        end else if (load) begin
            xl_valid <= 1'b1;
        end else if (next_allowin) begin
            xl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            xl_pkt <= nxt_pkt;
        end
    end

endmodule

/* rtl/mem_buf.sv */
`timescale 1ns/100ps

module mem_buf (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              flush,
    input  logic              prev_valid,
    input  mem_pkg::mem_pkt_t prev_pkt,
    input  logic              next_allowin,
    output logic              allowin,
    output logic              mb_valid,
    output mem_pkg::mem_pkt_t mb_pkt,
    output logic              dc_valid,
    output mem_pkg::dc_req_t  dc_req
);
    import uop_pkg::*;
    import mem_pkg::*;

    logic       excp_pend;
    logic       held_excp;
    logic       load;
    logic       move_out;
    logic [3:0] base_strb;

    // an excepting packet blocks intake until commit flushes
    assign held_excp = mb_valid && (mb_pkt.excp != NONE);
    assign allowin   = (!mb_valid || next_allowin) && !held_excp && !excp_pend;
    assign load      = prev_valid && allowin;
    assign move_out  = mb_valid && next_allowin;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            mb_valid <= 1'b0;
        end else if (flush) begin
            mb_valid <= 1'b0;
        end else if (load) begin
            mb_valid <= 1'b1;
        end else if (move_out) begin
            mb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mb_pkt <= prev_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            excp_pend <= 1'b0;
        end else if (flush) begin
            excp_pend <= 1'b0;
        end else if (load && prev_pkt.excp != NONE) begin
            excp_pend <= 1'b1;
        end
    end

    // byte lanes by size, before the word offset
    always_comb begin
        case (access_bytes(mb_pkt.op))
            3'd1:    base_strb = 4'b0001;
            3'd2:    base_strb = 4'b0011;
            default: base_strb = 4'b1111;
        endcase
    end

    always_comb begin
        dc_req.is_store  = is_store_op(mb_pkt.op);
        dc_req.is_atomic = is_atomic_op(mb_pkt.op);
        dc_req.strb      = base_strb << mb_pkt.value[1:0];
        dc_req.pa        = mb_pkt.value;
        dc_req.wdata     = mb_pkt.wdata << {mb_pkt.value[1:0], 3'b000};
    end

    // request goes out as the packet moves on to wb_tx
    // a flushed packet never reaches the cache
    assign dc_valid = move_out && !flush && is_mem_op(mb_pkt.op) && (mb_pkt.excp == NONE);

endmodule

/* rtl/wb_tx.sv */
`timescale 1ns/100ps

module wb_tx #(
    parameter int TX_CREDITS = 2
) (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              flush,
    input  logic              prev_valid,
    input  mem_pkg::mem_pkt_t prev_pkt,
    input  logic              out_credit,
    output logic              allowin,
    output logic              out_valid,
    output mem_pkg::wb_pkt_t  out_pkt
);
    import mem_pkg::*;

    localparam int CNT_W = $clog2(TX_CREDITS + 1);

    logic             tx_valid;
    wb_pkt_t          tx_pkt;
    logic [CNT_W-1:0] credits;
    logic             send;
    logic             load;

    // one-cycle send whenever a credit is held
    assign send      = tx_valid && (credits != '0);
    assign allowin   = !tx_valid || send;
    assign load      = prev_valid && allowin;
    assign out_valid = send;
    assign out_pkt   = tx_pkt;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tx_valid <= 1'b0;
        end else if (flush) begin
            tx_valid <= 1'b0;
        end else if (load) begin
            tx_valid <= 1'b1;
        end else if (send) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_pkt.pc    <= prev_pkt.pc;
            tx_pkt.rd    <= prev_pkt.rd;
            tx_pkt.op    <= prev_pkt.op;
            tx_pkt.value <= prev_pkt.value;
            tx_pkt.excp  <= prev_pkt.excp;
        end
    end

    // flush leaves the count alone, consumer credits still arrive
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            credits <= CNT_W'(TX_CREDITS);
        end else begin
            credits <= credits + CNT_W'(out_credit) - CNT_W'(send);
        end
    end

endmodule

/* rtl/mem_stage_top.sv */
`timescale 1ns/100ps

module mem_stage_top #(
    parameter int         RX_DEPTH   = 4,
    parameter int         TX_CREDITS = 2,
    parameter logic [2:0] DMW_VSEG   = 3'b101,
    parameter logic [2:0] DMW_PSEG   = 3'b000
) (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic                in_valid,
    input  uop_pkg::issue_pkt_t in_pkt,
    input  logic                out_credit,
    output logic                in_credit,
    output logic                out_valid,
    output mem_pkg::wb_pkt_t    out_pkt,
    output logic                dc_valid,
    output mem_pkg::dc_req_t    dc_req
);
    import uop_pkg::*;
    import mem_pkg::*;

    // issue_rx -> addr_xlate -> mem_buf -> wb_tx
    logic       rx_valid;
    issue_pkt_t rx_pkt;
    logic       xl_allowin;
    logic       xl_valid;
    mem_pkt_t   xl_pkt;
    logic       mb_allowin;
    logic       mb_valid;
    mem_pkt_t   mb_pkt;
    logic       tx_allowin;

    issue_rx #(
        .RX_DEPTH(RX_DEPTH)
    ) u_issue_rx (
        .clk(clk), .aresetn(aresetn), .flush(flush),
        .in_valid(in_valid), .in_pkt(in_pkt), .next_allowin(xl_allowin),
        .in_credit(in_credit), .rx_valid(rx_valid), .rx_pkt(rx_pkt)
    );

    addr_xlate #(
        .DMW_VSEG(DMW_VSEG), .DMW_PSEG(DMW_PSEG)
    ) u_addr_xlate (
        .clk(clk), .aresetn(aresetn), .flush(flush),
        .prev_valid(rx_valid), .prev_pkt(rx_pkt), .next_allowin(mb_allowin),
        .allowin(xl_allowin), .xl_valid(xl_valid), .xl_pkt(xl_pkt)
    );

    mem_buf u_mem_buf (
        .clk(clk), .aresetn(aresetn), .flush(flush),
        .prev_valid(xl_valid), .prev_pkt(xl_pkt), .next_allowin(tx_allowin),
        .allowin(mb_allowin), .mb_valid(mb_valid), .mb_pkt(mb_pkt),
        .dc_valid(dc_valid), .dc_req(dc_req)
    );

    wb_tx #(
        .TX_CREDITS(TX_CREDITS)
    ) u_wb_tx (
        .clk(clk), .aresetn(aresetn), .flush(flush),
        .prev_valid(mb_valid), .prev_pkt(mb_pkt), .out_credit(out_credit),
        .allowin(tx_allowin), .out_valid(out_valid), .out_pkt(out_pkt)
    );

endmodule

/* verification/mem_stage_tb.sv */
`timescale 1ns/100ps

module mem_stage_tb;
    import uop_pkg::*;
    import mem_pkg::*;

    localparam int         RX_DEPTH   = 4;
    localparam int         TX_CREDITS = 2;
    localparam logic [2:0] DMW_VSEG   = 3'b101;
    localparam logic [2:0] DMW_PSEG   = 3'b000;
    // random phases plus the directed exception packets
    localparam int         N_PKTS     = 60 + 30 + 20 + 6;
    localparam int         TIMEOUT    = 40 * N_PKTS + 200;

    logic        clk = 1'b0;
    logic        aresetn = 1'b0;
    logic        flush = 1'b0;
    logic        in_valid = 1'b0;
    issue_pkt_t  in_pkt = '0;
    logic        out_credit = 1'b0;
    logic        in_credit;
    logic        out_valid;
    wb_pkt_t     out_pkt;
    logic        dc_valid;
    dc_req_t     dc_req;

    // reference model and credit bookkeeping
    wb_pkt_t     exp_q[$];
    dc_req_t     dc_q[$];
    logic        excp_seen = 1'b0;
    excp_e       last_excp = NONE;
    int          snd_credits = RX_DEPTH;
    logic        credits_ran_out = 1'b0;
    int          tx_sent = 0;
    int          tx_returned = 0;
    int          mem_out = 0;
    int          dc_seen = 0;
    int          cycle_cnt = 0;
    int          hold_until = 0;
    logic [31:0] rng = 32'h30bd;
    logic [31:0] next_pc = 32'h1c00_0000;
    issue_pkt_t  pkt;

    mem_stage_top #(
        .RX_DEPTH(RX_DEPTH), .TX_CREDITS(TX_CREDITS),
        .DMW_VSEG(DMW_VSEG), .DMW_PSEG(DMW_PSEG)
    ) dut (
        .clk(clk), .aresetn(aresetn), .flush(flush),
        .in_valid(in_valid), .in_pkt(in_pkt), .out_credit(out_credit),
        .in_credit(in_credit), .out_valid(out_valid), .out_pkt(out_pkt),
        .dc_valid(dc_valid), .dc_req(dc_req)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    function automatic int op_size(input op_e op);
        case (op)
            LD_B, ST_B: return 1;
            LD_H, ST_H: return 2;
            default:    return 4;
        endcase
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [79:0] expv,
                                 input logic [79:0] actv);
        assert (actv === expv) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expv, actv);
            abort_run();
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            abort_run();
        end
    endtask

    // expected writeback packet and cache request for one accepted micro-op
    task automatic predict(input issue_pkt_t p);
        wb_pkt_t     w;
        dc_req_t     d;
        logic [31:0] va;
        int          size;
        va      = p.rj_data + p.imm;
        size    = op_size(p.op);
        w.pc    = p.pc;
        w.rd    = p.rd;
        w.op    = p.op;
        w.value = va;
        w.excp  = NONE;
        if (p.op != ALU_ADD) begin
            if (va % size != 0) begin
                w.excp = ALE;
            end else if (va[31:29] != DMW_VSEG) begin
                w.excp = TLBR;
            end else begin
                w.value = {DMW_PSEG, va[28:0]};
            end
        end
        // everything behind an exception is stuck until flush
        if (!excp_seen) begin
            exp_q.push_back(w);
            if (p.op != ALU_ADD && w.excp == NONE) begin
                d.is_store  = p.op inside {ST_B, ST_H, ST_W, SC_W};
                d.is_atomic = p.op inside {LL_W, SC_W};
                d.strb      = (size == 1) ? (4'b0001 << va[1:0]) :
                              (size == 2) ? (4'b0011 << va[1:0]) : 4'b1111;
                d.pa        = w.value;
                d.wdata     = p.rk_data << (8 * va[1:0]);
                dc_q.push_back(d);
            end
            excp_seen = (w.excp != NONE);
        end
    endtask

    always @(posedge clk) begin
        wb_pkt_t w;
        dc_req_t d;
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", TIMEOUT);
            abort_run();
        end
        // reset covers edges 1 to 16 and four quiet edges follow before stimulus
        if (cycle_cnt > 1 && cycle_cnt <= 20) begin
            require(!in_credit && !out_valid && !dc_valid,
                    "in_credit, out_valid or dc_valid active during or right after reset");
        end
        if (aresetn) begin
            if (out_valid) begin
                require(exp_q.size() > 0, "out_valid with no packet expected");
                require(tx_sent - tx_returned < TX_CREDITS, "out_valid without a credit");
                w = exp_q.pop_front();
                compare_value("out_pkt", w, out_pkt);
                last_excp = out_pkt.excp;
                tx_sent++;
                if (w.op != ALU_ADD && w.excp == NONE) begin
                    mem_out++;
                    require(mem_out <= dc_seen, "memory packet left before its dc_valid");
                end
            end
            if (out_credit) begin
                tx_returned++;
            end
            if (dc_valid) begin
                require(dc_q.size() > 0, "dc_valid with no cache request expected");
                d = dc_q.pop_front();
                compare_value("dc_req", d, dc_req);
                dc_seen++;
            end
            if (in_credit) begin
                snd_credits++;
                require(snd_credits <= RX_DEPTH, "more issue credits returned than taken");
            end
            if (in_valid) begin
                snd_credits--;
                if (snd_credits == 0) begin
                    credits_ran_out = 1'b1;
                end
                predict(in_pkt);
            end
            if (flush) begin
                exp_q.delete();
                dc_q.delete();
                excp_seen = 1'b0;
                dc_seen   = mem_out;
            end
        end
    end

    // consumer returns credits on two of three cycles unless held back
    always @(posedge clk) begin
        #2;
        out_credit = (tx_sent > tx_returned) && (cycle_cnt >= hold_until)
                     && (cycle_cnt % 3 != 0);
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic make_pkt(output issue_pkt_t p);
        logic [31:0] r;
        logic [1:0]  off;
        draw(r);
        p.op    = op_e'(r[3:0] % 4'd9);
        p.rd    = r[8:4];
        p.pc    = next_pc;
        next_pc = next_pc + 32'd4;
        draw(r);
        // mostly inside the window
        p.rj_data = {((r[2:0] == 3'd0) ? r[31:29] : DMW_VSEG), r[28:12], 12'd0};
        draw(r);
        off = r[1:0];
        if (r[6:4] != 3'd0) begin
            if (op_size(p.op) == 4) begin
                off = 2'b00;
            end else if (op_size(p.op) == 2) begin
                off[0] = 1'b0;
            end
        end
        p.imm = {20'd0, r[11:2], off};
        draw(r);
        p.rk_data = r;
    endtask

    task automatic flush_pipe(input int pre_wait);
        repeat (pre_wait) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        while (snd_credits != RX_DEPTH) next_cycle();
        repeat (2) next_cycle();
    endtask

    task automatic send_pkt(input issue_pkt_t p);
        while (snd_credits == 0 || (excp_seen && exp_q.size() == 0)) begin
            if (excp_seen && exp_q.size() == 0) begin
                flush_pipe(3);
            end else begin
                next_cycle();
            end
        end
        in_valid = 1'b1;
        in_pkt   = p;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic excp_case(input op_e op, input logic [31:0] va, input excp_e want);
        issue_pkt_t p;
        make_pkt(p);
        p.op      = op;
        p.rj_data = va;
        p.imm     = '0;
        send_pkt(p);
        make_pkt(p);
        p.op = ALU_ADD;
        send_pkt(p);
        while (exp_q.size() != 0) next_cycle();
        compare_value("out_pkt.excp", want, last_excp);
        flush_pipe(6);
    endtask

    initial begin
        repeat (16) @(posedge clk);
        #2;
        aresetn = 1'b1;
        repeat (4) next_cycle();
        repeat (60) begin
            make_pkt(pkt);
            send_pkt(pkt);
        end
        // writeback back-pressure
        hold_until = cycle_cnt + 60;
        repeat (30) begin
            make_pkt(pkt);
            send_pkt(pkt);
        end
        repeat (10) begin
            make_pkt(pkt);
            send_pkt(pkt);
        end
        flush_pipe(1);
        repeat (10) begin
            make_pkt(pkt);
            send_pkt(pkt);
        end
        if (excp_seen) flush_pipe(3);
        excp_case(LD_W, 32'h4000_0002, ALE);
        excp_case(ST_H, 32'h6000_0010, TLBR);
        excp_case(LD_H, {DMW_VSEG, 29'h0000_1001}, ALE);
        while (exp_q.size() != 0 || snd_credits != RX_DEPTH) next_cycle();
        repeat (10) next_cycle();
        require(dc_q.size() == 0, "cache requests expected but never seen");
        require(credits_ran_out, "issue credits never ran out under writeback back-pressure");
        $display("test passed");
        $finish;
    end

endmodule

/* list.f */
rtl/uop_pkg.sv
rtl/mem_pkg.sv
rtl/issue_rx.sv
rtl/addr_xlate.sv
rtl/mem_buf.sv
rtl/wb_tx.sv
rtl/mem_stage_top.sv
verification/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - rtl/uop_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/issue_rx.sv
  - rtl/addr_xlate.sv
  - rtl/mem_buf.sv
  - rtl/wb_tx.sv
  - rtl/mem_stage_top.sv
  - target: test
    files:
      - verification/mem_stage_tb.sv
